//--- logic/rv_decode_pkg.sv
package rv_decode_pkg;

    // data, instruction and pc values.
    typedef logic [31:0] word_t;

    // register index, x0 to x31.
    typedef logic [4:0] reg_addr_t;

    // major opcode, instr[6:0].
    typedef logic [6:0] opcode_t;

    // second alu operand select.
    typedef logic [1:0] op2_sel_t;

    localparam op2_sel_t CTRL_OP2_REG  = 2'b00; // rs2.
    localparam op2_sel_t CTRL_OP2_IMM  = 2'b01; // immediate.
    localparam op2_sel_t CTRL_OP2_FOUR = 2'b10; // constant 4, link address.

    // rv32i base opcodes.
    localparam opcode_t OP_ARITHMETIC     = 7'b0110011;
    localparam opcode_t OP_ARITHMETIC_IMM = 7'b0010011;
    localparam opcode_t OP_LOAD           = 7'b0000011;
    localparam opcode_t OP_STORE          = 7'b0100011;
    localparam opcode_t OP_BRANCH         = 7'b1100011;
    localparam opcode_t OP_JAL            = 7'b1101111;
    localparam opcode_t OP_JALR           = 7'b1100111;
    localparam opcode_t OP_LUI            = 7'b0110111;
    localparam opcode_t OP_AUIPC          = 7'b0010111;
    localparam opcode_t OP_ECALL          = 7'b1110011; // system opcode, only ecall decoded.

    // issue state, halted is sticky until reset.
    typedef enum logic {
        ISSUE_RUN    = 1'b0,
        ISSUE_HALTED = 1'b1
    } issue_state_t;

endpackage

//--- logic/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  rv_decode_pkg::opcode_t  opcode,
    output logic                    wb_enable,
    output logic                    mem_enable,
    output logic                    mem_write,
    output logic                    op1_pc,
    output rv_decode_pkg::op2_sel_t op2_sel,
    output logic                    is_ecall,
    output logic                    rs2_used,
    output logic                    ex_forwardable,
    output logic                    is_branch,
    output logic                    is_jalr
);

    always_comb begin
        // unknown opcodes fall through with everything cleared.
        wb_enable      = 1'b0;
        mem_enable     = 1'b0;
        mem_write      = 1'b0;
        op1_pc         = 1'b0;
        op2_sel        = rv_decode_pkg::CTRL_OP2_REG;
        is_ecall       = 1'b0;
        rs2_used       = 1'b0;
        ex_forwardable = 1'b0;
        is_branch      = 1'b0;
        is_jalr        = 1'b0;

        case (opcode)
            rv_decode_pkg::OP_ARITHMETIC: begin
                wb_enable      = 1'b1;
                rs2_used       = 1'b1;
                ex_forwardable = 1'b1;
            end
            rv_decode_pkg::OP_ARITHMETIC_IMM: begin
                wb_enable      = 1'b1;
                op2_sel        = rv_decode_pkg::CTRL_OP2_IMM;
                ex_forwardable = 1'b1;
            end
            rv_decode_pkg::OP_LOAD: begin
                wb_enable  = 1'b1;
                mem_enable = 1'b1;
                op2_sel    = rv_decode_pkg::CTRL_OP2_IMM; // result only after mem.
            end
            rv_decode_pkg::OP_STORE: begin
                mem_enable = 1'b1;
                mem_write  = 1'b1;
                op2_sel    = rv_decode_pkg::CTRL_OP2_IMM;
                rs2_used   = 1'b1; // store data.
            end
            rv_decode_pkg::OP_BRANCH: begin
                rs2_used  = 1'b1;
                is_branch = 1'b1;
            end
            rv_decode_pkg::OP_JAL: begin
                wb_enable      = 1'b1;
                op1_pc         = 1'b1;
                op2_sel        = rv_decode_pkg::CTRL_OP2_FOUR;
                ex_forwardable = 1'b1;
                is_branch      = 1'b1;
            end
            rv_decode_pkg::OP_JALR: begin
                wb_enable      = 1'b1;
                op2_sel        = rv_decode_pkg::CTRL_OP2_FOUR;
                ex_forwardable = 1'b1;
                is_branch      = 1'b1;
                is_jalr        = 1'b1;
            end
            rv_decode_pkg::OP_LUI: begin
                wb_enable      = 1'b1;
                op2_sel        = rv_decode_pkg::CTRL_OP2_IMM;
                ex_forwardable = 1'b1;
            end
            rv_decode_pkg::OP_AUIPC: begin
                wb_enable      = 1'b1;
                op1_pc         = 1'b1; // pc + upper immediate.
                op2_sel        = rv_decode_pkg::CTRL_OP2_IMM;
                ex_forwardable = 1'b1;
            end
            rv_decode_pkg::OP_ECALL: begin
                is_ecall = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- logic/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  rv_decode_pkg::word_t instr,
    output rv_decode_pkg::word_t imm
);

    rv_decode_pkg::opcode_t opcode;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            // i-type.
            rv_decode_pkg::OP_ARITHMETIC_IMM,
            rv_decode_pkg::OP_LOAD,
            rv_decode_pkg::OP_JALR: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            rv_decode_pkg::OP_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv_decode_pkg::OP_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            // u-type, low 12 bits zero.
            rv_decode_pkg::OP_LUI,
            rv_decode_pkg::OP_AUIPC: begin
                imm = {instr[31:12], 12'b0};
            end
            rv_decode_pkg::OP_JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // r-type and system carry no immediate.
            end
        endcase
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_decode_pkg::reg_addr_t rs1,
    input  rv_decode_pkg::reg_addr_t rs2,
    output rv_decode_pkg::word_t     rs1_data,
    output rv_decode_pkg::word_t     rs2_data,
    input  logic                    wb_we,
    input  rv_decode_pkg::reg_addr_t wb_rd,
    input  rv_decode_pkg::word_t     wb_data
);

    rv_decode_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // x0 first, then writeback bypass, then array.
    function automatic rv_decode_pkg::word_t read_port(input rv_decode_pkg::reg_addr_t addr);
        rv_decode_pkg::word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb_we && (wb_rd == addr)) begin
            value = wb_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);

endmodule

//--- logic/issue_control.sv
`timescale 1ns/1ps

module issue_control (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     if_valid,
    input  rv_decode_pkg::reg_addr_t rs1,
    input  rv_decode_pkg::reg_addr_t rs2,
    input  logic                     rs2_used,
    input  logic                     is_ecall,
    input  logic                     ex_valid,
    input  logic                     ex_load,
    input  rv_decode_pkg::reg_addr_t ex_rd,
    output logic                     id_ready,
    output logic                     load_use_stall
);

    rv_decode_pkg::issue_state_t state;
    logic                        rs1_hit;
    logic                        rs2_hit;
    logic                        accept;

    // load result is not ready for execute in the next cycle.
    assign rs1_hit = (ex_rd == rs1);
    assign rs2_hit = rs2_used && (ex_rd == rs2);

    assign load_use_stall = if_valid && ex_valid && ex_load && (ex_rd != '0) &&
                            (rs1_hit || rs2_hit);

    assign id_ready = (state == rv_decode_pkg::ISSUE_RUN) && !load_use_stall;
    assign accept   = if_valid && id_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= rv_decode_pkg::ISSUE_RUN;
        end else if (accept && is_ecall) begin
            state <= rv_decode_pkg::ISSUE_HALTED; // only reset leaves this.
        end
    end

endmodule

//--- logic/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_use_stall,
    input  logic                     accept,
    input  rv_decode_pkg::word_t     pc,
    input  rv_decode_pkg::word_t     instr,
    input  rv_decode_pkg::word_t     rs1_data,
    input  rv_decode_pkg::word_t     rs2_data,
    input  rv_decode_pkg::word_t     imm,
    input  rv_decode_pkg::reg_addr_t rd,
    input  logic                     wb_enable,
    input  logic                     mem_enable,
    input  logic                     mem_write,
    input  logic                     op1_pc,
    input  rv_decode_pkg::op2_sel_t  op2_sel,
    input  logic                     is_branch,
    input  logic                     is_jalr,
    input  logic                     ex_forwardable,
    output logic                     ex_valid,
    output rv_decode_pkg::word_t     ex_pc,
    output rv_decode_pkg::word_t     ex_instr,
    output rv_decode_pkg::word_t     ex_rs1_data,
    output rv_decode_pkg::word_t     ex_rs2_data,
    output rv_decode_pkg::word_t     ex_imm,
    output rv_decode_pkg::reg_addr_t ex_rd,
    output logic                     ex_wb_enable,
    output logic                     ex_mem_enable,
    output logic                     ex_mem_write,
    output logic                     ex_op1_pc,
    output rv_decode_pkg::op2_sel_t  ex_op2_sel,
    output logic                     ex_is_branch,
    output logic                     ex_is_jalr,
    output logic                     ex_ex_forwardable,
    output logic                     ex_load
);

    logic capture;

    assign capture = accept && !load_use_stall;

    // valid and controls, cleared for a bubble.
    always_ff @(posedge clk) begin
        if (!rst_n || !capture) begin
            ex_valid          <= 1'b0;
            ex_wb_enable      <= 1'b0;
            ex_mem_enable     <= 1'b0;
            ex_mem_write      <= 1'b0;
            ex_op1_pc         <= 1'b0;
            ex_op2_sel        <= rv_decode_pkg::CTRL_OP2_REG;
            ex_is_branch      <= 1'b0;
            ex_is_jalr        <= 1'b0;
            ex_ex_forwardable <= 1'b0;
            ex_load           <= 1'b0;
        end else begin
            ex_valid          <= 1'b1;
            ex_wb_enable      <= wb_enable;
            ex_mem_enable     <= mem_enable;
            ex_mem_write      <= mem_write;
            ex_op1_pc         <= op1_pc;
            ex_op2_sel        <= op2_sel;
            ex_is_branch      <= is_branch;
            ex_is_jalr        <= is_jalr;
            ex_ex_forwardable <= ex_forwardable;
            ex_load           <= wb_enable && mem_enable && !mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            ex_pc       <= pc;
            ex_instr    <= instr; // funct3/funct7 for execute.
            ex_rs1_data <= rs1_data;
            ex_rs2_data <= rs2_data;
            ex_imm      <= imm;
            ex_rd       <= rd;
        end
    end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     if_valid,
    input  rv_decode_pkg::word_t     if_instr,
    input  rv_decode_pkg::word_t     if_pc,
    output logic                     id_ready,
    input  logic                     wb_we,
    input  rv_decode_pkg::reg_addr_t wb_rd,
    input  rv_decode_pkg::word_t     wb_data,
    output logic                     ex_valid,
    output rv_decode_pkg::word_t     ex_pc,
    output rv_decode_pkg::word_t     ex_rs1_data,
    output rv_decode_pkg::word_t     ex_rs2_data,
    output rv_decode_pkg::word_t     ex_imm,
    output rv_decode_pkg::reg_addr_t ex_rd,
    output rv_decode_pkg::word_t     ex_instr,
    output logic                     ex_wb_enable,
    output logic                     ex_mem_enable,
    output logic                     ex_mem_write,
    output logic                     ex_op1_pc,
    output rv_decode_pkg::op2_sel_t  ex_op2_sel,
    output logic                     ex_is_branch,
    output logic                     ex_is_jalr,
    output logic                     ex_ex_forwardable
);

    rv_decode_pkg::reg_addr_t rs1;
    rv_decode_pkg::reg_addr_t rs2;
    rv_decode_pkg::reg_addr_t rd;
    rv_decode_pkg::word_t     rs1_data;
    rv_decode_pkg::word_t     rs2_data;
    rv_decode_pkg::word_t     imm;
    rv_decode_pkg::op2_sel_t  op2_sel;
    logic wb_enable;
    logic mem_enable;
    logic mem_write;
    logic op1_pc;
    logic is_ecall;
    logic rs2_used;
    logic ex_forwardable;
    logic is_branch;
    logic is_jalr;
    logic load_use_stall;
    logic accept;
    logic ex_load;

    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign rd     = if_instr[11:7];
    assign accept = if_valid && id_ready; // fetch handshake.

    control_unit control_i (
        .opcode(if_instr[6:0]), .wb_enable(wb_enable), .mem_enable(mem_enable),
        .mem_write(mem_write), .op1_pc(op1_pc), .op2_sel(op2_sel), .is_ecall(is_ecall),
        .rs2_used(rs2_used), .ex_forwardable(ex_forwardable), .is_branch(is_branch),
        .is_jalr(is_jalr)
    );

    imm_gen imm_i (.instr(if_instr), .imm(imm));

    reg_file reg_file_i (
        .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    issue_control issue_i (
        .clk(clk), .rst_n(rst_n), .if_valid(if_valid), .rs1(rs1), .rs2(rs2),
        .rs2_used(rs2_used), .is_ecall(is_ecall), .ex_valid(ex_valid), .ex_load(ex_load),
        .ex_rd(ex_rd), .id_ready(id_ready), .load_use_stall(load_use_stall)
    );

    id_ex_reg id_ex_i (
        .clk(clk), .rst_n(rst_n), .load_use_stall(load_use_stall), .accept(accept),
        .pc(if_pc), .instr(if_instr), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .rd(rd), .wb_enable(wb_enable), .mem_enable(mem_enable), .mem_write(mem_write),
        .op1_pc(op1_pc), .op2_sel(op2_sel), .is_branch(is_branch), .is_jalr(is_jalr),
        .ex_forwardable(ex_forwardable), .ex_valid(ex_valid), .ex_pc(ex_pc),
        .ex_instr(ex_instr), .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
        .ex_imm(ex_imm), .ex_rd(ex_rd), .ex_wb_enable(ex_wb_enable),
        .ex_mem_enable(ex_mem_enable), .ex_mem_write(ex_mem_write), .ex_op1_pc(ex_op1_pc),
        .ex_op2_sel(ex_op2_sel), .ex_is_branch(ex_is_branch), .ex_is_jalr(ex_is_jalr),
        .ex_ex_forwardable(ex_ex_forwardable), .ex_load(ex_load)
    );

endmodule

//--- tb/decode_stage_properties.sv
`timescale 1ns/1ps

module decode_stage_properties (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        id_ready,
    input logic                        ex_valid,
    input logic                        load_use_stall,
    input rv_decode_pkg::issue_state_t state
);

    int fail_count = 0; // failed assertion count.

    // the register comes out of reset empty.
    a_reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !ex_valid)
        else begin
            $error("ex_valid high in the cycle after reset");
            fail_count++;
        end

    a_halted_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (state == rv_decode_pkg::ISSUE_HALTED) |-> !id_ready)
        else begin
            $error("id_ready high while issue is halted");
            fail_count++;
        end

    // a stalled cycle must leave a bubble behind it.
    a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        load_use_stall |=> !ex_valid)
        else begin
            $error("ex_valid high after a load-use stall");
            fail_count++;
        end

endmodule

bind decode_stage decode_stage_properties props_i (
    .clk(clk),
    .rst_n(rst_n),
    .id_ready(id_ready),
    .ex_valid(ex_valid),
    .load_use_stall(load_use_stall),
    .state(issue_i.state)
);

//--- tb/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

    logic                     clk;
    logic                     rst_n;
    logic                     if_valid;
    rv_decode_pkg::word_t     if_instr;
    rv_decode_pkg::word_t     if_pc;
    logic                     id_ready;
    logic                     wb_we;
    rv_decode_pkg::reg_addr_t wb_rd;
    rv_decode_pkg::word_t     wb_data;
    logic                     ex_valid;
    rv_decode_pkg::word_t     ex_pc;
    rv_decode_pkg::word_t     ex_rs1_data;
    rv_decode_pkg::word_t     ex_rs2_data;
    rv_decode_pkg::word_t     ex_imm;
    rv_decode_pkg::reg_addr_t ex_rd;
    rv_decode_pkg::word_t     ex_instr;
    logic                     ex_wb_enable;
    logic                     ex_mem_enable;
    logic                     ex_mem_write;
    logic                     ex_op1_pc;
    rv_decode_pkg::op2_sel_t  ex_op2_sel;
    logic                     ex_is_branch;
    logic                     ex_is_jalr;
    logic                     ex_ex_forwardable;

    int          error_count;
    int          line_no;
    logic [31:0] field [14];  // one parsed vector line.
    logic        pending;     // an ex_ expectation waits for the next edge.
    logic [31:0] exp_valid;
    logic [31:0] exp_pc;
    logic [31:0] exp_instr;
    logic [31:0] exp_rs1;
    logic [31:0] exp_rs2;
    logic [31:0] exp_imm;
    logic [31:0] exp_rd;
    logic [31:0] exp_ctrl;

    decode_stage dut_i (
        .clk(clk), .rst_n(rst_n), .if_valid(if_valid), .if_instr(if_instr), .if_pc(if_pc),
        .id_ready(id_ready), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_rs1_data(ex_rs1_data),
        .ex_rs2_data(ex_rs2_data), .ex_imm(ex_imm), .ex_rd(ex_rd), .ex_instr(ex_instr),
        .ex_wb_enable(ex_wb_enable), .ex_mem_enable(ex_mem_enable),
        .ex_mem_write(ex_mem_write), .ex_op1_pc(ex_op1_pc), .ex_op2_sel(ex_op2_sel),
        .ex_is_branch(ex_is_branch), .ex_is_jalr(ex_is_jalr),
        .ex_ex_forwardable(ex_ex_forwardable)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR: %s expected 0x%h got 0x%h (vector line %0d)",
                     name, expected, actual, line_no);
            stop_run("stopping at the first mismatch");
        end
    endtask

    task automatic check_assertions();
        if (dut_i.props_i.fail_count != 0) begin
            stop_run("a bound assertion on the decode stage failed");
        end
    endtask

    // comment lines start with '#', blank lines are skipped.
    function automatic bit is_vector_line(input string text);
        return (text.len() > 1) && (text[0] != "#") && (text[0] != "\n");
    endfunction

    task automatic check_ex_outputs();
        logic [31:0] ctrl;
        ctrl = {23'b0, ex_wb_enable, ex_mem_enable, ex_mem_write, ex_op1_pc, ex_op2_sel,
                ex_is_branch, ex_is_jalr, ex_ex_forwardable};
        check_value("ex_valid", {31'b0, ex_valid}, exp_valid);
        check_value("ex_ctrl", ctrl, exp_ctrl);
        if (exp_valid[0]) begin // datapath fields hold stale values in a bubble.
            check_value("ex_pc", ex_pc, exp_pc);
            check_value("ex_instr", ex_instr, exp_instr);
            check_value("ex_rs1_data", ex_rs1_data, exp_rs1);
            check_value("ex_rs2_data", ex_rs2_data, exp_rs2);
            check_value("ex_imm", ex_imm, exp_imm);
            check_value("ex_rd", {27'b0, ex_rd}, exp_rd);
        end
    endtask

    initial begin
        int    fd;
        int    tries;
        int    cycles;
        int    code;
        string text;

        rst_n    = 1'b0;
        if_valid = 1'b0;
        if_instr = '0;
        if_pc    = '0;
        wb_we    = 1'b0;
        wb_rd    = '0;
        wb_data  = '0;
        error_count = 0;
        line_no     = 0;
        pending     = 1'b0;

        fd    = 0;
        tries = 0;
        while (fd == 0) begin
            fd = $fopen("tb/decode_vectors.txt", "r");
            if (fd == 0) begin
                tries++;
                if (tries >= 10) begin
                    stop_run("could not open tb/decode_vectors.txt");
                end
                @(posedge clk);
            end
        end

        repeat (2) @(posedge clk);

        cycles = 0;
        while (!$feof(fd)) begin
            cycles++;
            if (cycles > 200) begin
                stop_run("vector file did not end within 200 cycles");
            end
            code = $fgets(text, fd);
            line_no++;
            if (code != 0 && is_vector_line(text)) begin
                code = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               field[0], field[1], field[2], field[3], field[4],
                               field[5], field[6], field[7], field[8], field[9],
                               field[10], field[11], field[12], field[13]);
                if (code != 14) begin
                    stop_run("malformed line in the vector file");
                end
                rst_n    <= field[0][0];
                if_valid <= field[1][0];
                if_instr <= field[2];
                if_pc    <= field[3];
                wb_we    <= field[4][0];
                wb_rd    <= field[5][4:0];
                wb_data  <= field[6];
                @(negedge clk);
                check_assertions();
                check_value("id_ready", {31'b0, id_ready}, field[7]);
                if (pending) begin
                    check_ex_outputs();
                end
                pending   = 1'b1;
                exp_valid = field[8];
                exp_pc    = field[3]; // pc and instr of this line's transfer.
                exp_instr = field[2];
                exp_rs1   = field[9];
                exp_rs2   = field[10];
                exp_imm   = field[11];
                exp_rd    = field[12];
                exp_ctrl  = field[13];
                @(posedge clk);
            end
        end
        $fclose(fd);

        @(negedge clk);
        check_assertions();
        if (pending) begin
            check_ex_outputs(); // last line's result.
        end

        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- rv_decode.f
logic/rv_decode_pkg.sv
logic/control_unit.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/issue_control.sv
logic/id_ex_reg.sv
logic/decode_stage.sv
tb/decode_stage_properties.sv
tb/decode_stage_tb.sv

//--- tb/decode_vectors.txt
# rst_n if_valid if_instr if_pc wb_we wb_rd wb_data | id_ready | after the edge:
# ex_valid ex_rs1_data ex_rs2_data ex_imm ex_rd ctrl{wb,mem,mwr,op1pc,op2[1:0],br,jalr,fwd}
1 0 00000000 00000000 1 01 11111111 1 0 00000000 00000000 00000000 00 000
1 0 00000000 00000000 1 02 deadbeef 1 0 00000000 00000000 00000000 00 000
1 0 00000000 00000000 1 00 55555555 1 0 00000000 00000000 00000000 00 000
1 1 002081b3 00000100 0 00 00000000 1 1 11111111 deadbeef 00000000 03 101
1 1 fff28213 00000104 1 05 0000abcd 1 1 0000abcd 00000000 ffffffff 04 109
1 1 00000333 00000108 1 00 ffffffff 1 1 00000000 00000000 00000000 06 101
1 1 fe20ac23 0000010c 0 00 00000000 1 1 11111111 deadbeef fffffff8 18 0c8
1 1 fe2088e3 00000110 0 00 00000000 1 1 11111111 deadbeef fffffff0 11 004
1 1 001003ef 00000114 0 00 00000000 1 1 00000000 11111111 00000800 07 135
1 1 00410467 00000118 0 00 00000000 1 1 deadbeef 00000000 00000004 08 117
1 1 800004b7 0000011c 0 00 00000000 1 1 00000000 00000000 80000000 09 109
1 1 12345517 00000120 0 00 00000000 1 1 00000000 00000000 12345000 0a 129
1 1 0000007f 00000124 0 00 00000000 1 1 00000000 00000000 00000000 00 000
1 1 0000a583 00000128 0 00 00000000 1 1 11111111 00000000 00000000 0b 188
1 1 00258633 0000012c 0 00 00000000 0 0 00000000 00000000 00000000 00 000
1 1 00258633 0000012c 1 0b cafef00d 1 1 cafef00d deadbeef 00000000 0c 101
1 1 00412683 00000130 0 00 00000000 1 1 deadbeef 00000000 00000004 0d 188
1 1 00d0a023 00000134 0 00 00000000 0 0 00000000 00000000 00000000 00 000
1 1 00d0a023 00000134 1 0d 13131313 1 1 11111111 13131313 00000000 00 0c8
1 1 0000a003 00000138 0 00 00000000 1 1 11111111 00000000 00000000 00 188
1 1 00000733 0000013c 0 00 00000000 1 1 00000000 00000000 00000000 0e 101
1 1 0000a783 00000140 0 00 00000000 1 1 11111111 00000000 00000000 0f 188
1 1 00f08813 00000144 0 00 00000000 1 1 11111111 00000000 0000000f 10 109
1 1 00000073 00000148 0 00 00000000 1 1 00000000 00000000 00000000 00 000
1 1 002081b3 0000014c 0 00 00000000 0 0 00000000 00000000 00000000 00 000
1 1 002081b3 0000014c 0 00 00000000 0 0 00000000 00000000 00000000 00 000
0 1 002081b3 0000014c 0 00 00000000 0 0 00000000 00000000 00000000 00 000
1 1 002081b3 0000014c 0 00 00000000 1 1 00000000 00000000 00000000 03 101
1 0 00000000 00000000 0 00 00000000 1 0 00000000 00000000 00000000 00 000
